//--- hdl/sub_bus_cfg.svh
// sub bus configuration defines for bank count, bank size and bank wait states
`ifndef SUB_BUS_CFG_SVH
`define SUB_BUS_CFG_SVH

// number of identical banks, decoded from address bits 19..17
`define SUB_BANKS 4

// word address bits inside one bank
`define BANK_AW 8

// cycles from a bank select to its ok
`define BANK_WAIT 2

// address field that picks the bank
`define REGION_HI 19
`define REGION_LO 17

`endif

//--- hdl/bus_pkg.sv
// bus types for the shared 68000-style sub bus and the arbiter state encoding
package bus_pkg;

    // word address, bit 0 is carried by the byte strobes
    typedef logic [19:1] addr_t;

    // one bus data word
    typedef logic [15:0] data_t;

    // byte strobes, active low, upper lane in bit 1
    typedef logic [1:0] lanes_t;

    // bus ownership
    typedef enum logic [1:0] {
        SUB_OWN    = 2'd0, // sub master drives the bus
        GRANT_WAIT = 2'd1, // request seen, sub access still running
        MAIN_OWN   = 2'd2  // main master drives the bus
    } arb_state_t;

endpackage

//--- hdl/map_pkg.sv
// memory map types for the bank selects, the region field and the word offset
`include "sub_bus_cfg.svh"

package map_pkg;

    // one bit per bank, at most one set
    typedef logic [`SUB_BANKS-1:0] bank_sel_t;

    // word offset inside a bank
    typedef logic [`BANK_AW-1:0] offset_t;

    // address bits 19..17, banks sit at the low values
    typedef logic [`REGION_HI-`REGION_LO:0] region_t;

endpackage

//--- hdl/bus_arbiter.sv
// bus arbiter that hands the shared bus to the sub or main master and routes the answer back
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                sub_as,
    input  logic                sub_rnw,
    input  bus_pkg::addr_t      sub_addr,
    input  bus_pkg::lanes_t     sub_dsn,
    input  bus_pkg::data_t      sub_dout,
    input  logic                main_br,
    input  logic                main_as,
    input  logic                main_rnw,
    input  bus_pkg::addr_t      main_addr,
    input  bus_pkg::lanes_t     main_dsn,
    input  bus_pkg::data_t      main_dout,
    input  logic                bus_ack,
    input  bus_pkg::data_t      bus_rdata,
    output logic                sub_dtackn,
    output bus_pkg::data_t      sub_din,
    output logic                main_bg,
    output logic                main_ok,
    output bus_pkg::data_t      main_din,
    output logic                bus_as,
    output logic                bus_rnw,
    output bus_pkg::addr_t      bus_addr,
    output bus_pkg::lanes_t     bus_dsn,
    output bus_pkg::data_t      bus_wdata
);
    bus_pkg::arb_state_t state;
    logic                main_own;

    assign main_own = (state == bus_pkg::MAIN_OWN);

    // owner drives the shared bus, the other strobe never reaches it
    assign bus_as    = main_own ? main_as   : sub_as;
    assign bus_rnw   = main_own ? main_rnw  : sub_rnw;
    assign bus_addr  = main_own ? main_addr : sub_addr;
    assign bus_dsn   = main_own ? main_dsn  : sub_dsn;
    assign bus_wdata = main_own ? main_dout : sub_dout;

    assign sub_dtackn = ~(bus_ack & ~main_own); // sub stalls while main owns
    assign main_ok    = bus_ack & main_own;
    assign sub_din    = main_own ? '1 : bus_rdata;
    assign main_din   = main_own ? bus_rdata : '1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= bus_pkg::SUB_OWN;
            main_bg <= 1'b0;
        end else begin
            case (state)
                bus_pkg::SUB_OWN: begin
                    if (main_br && sub_as) begin // sub idle, grant now
                        state   <= bus_pkg::MAIN_OWN;
                        main_bg <= 1'b1;
                    end else if (main_br) begin
                        state <= bus_pkg::GRANT_WAIT;
                    end
                end
                bus_pkg::GRANT_WAIT: begin
                    if (!main_br) begin // request withdrawn
                        state <= bus_pkg::SUB_OWN;
                    end else if (sub_as) begin // sub strobe released
                        state   <= bus_pkg::MAIN_OWN;
                        main_bg <= 1'b1;
                    end
                end
                bus_pkg::MAIN_OWN: begin
                    if (!main_br) begin
                        state   <= bus_pkg::SUB_OWN;
                        main_bg <= 1'b0;
                    end
                end
                default: begin
                    state   <= bus_pkg::SUB_OWN;
                    main_bg <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- hdl/addr_decoder.sv
// address decoder with registered one-hot bank selects, unmapped flag and word offset
`timescale 1ns/1ps
`include "sub_bus_cfg.svh"

module addr_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                bus_as,
    input  bus_pkg::addr_t      bus_addr,
    output map_pkg::bank_sel_t  bank_sel,
    output logic                unmapped,
    output map_pkg::offset_t    offset
);
    map_pkg::region_t   region;
    logic               mapped;
    map_pkg::bank_sel_t sel_next;

    assign region = bus_addr[`REGION_HI:`REGION_LO];
    assign mapped = (region < `SUB_BANKS);

    always_comb begin
        sel_next = '0;
        for (int i = 0; i < `SUB_BANKS; i++) begin
            if (region == map_pkg::region_t'(i)) begin
                sel_next[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_sel <= '0;
            unmapped <= 1'b0;
        end else if (!bus_as) begin // strobe low, decode the held address
            bank_sel <= sel_next;
            unmapped <= ~mapped;
        end else begin
            bank_sel <= '0;
            unmapped <= 1'b0;
        end
    end

    // offset follows the address so it lines up with the select
    always_ff @(posedge clk) begin
        if (!bus_as) begin
            offset <= bus_addr[`BANK_AW:1];
        end
    end

endmodule

//--- hdl/mem_bank.sv
// memory bank with byte-lane writes and a fixed wait-state counter that raises ok
`timescale 1ns/1ps

module mem_bank #(
    parameter int AW   = 8,
    parameter int WAIT = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                sel,
    input  map_pkg::offset_t    offset,
    input  logic                bus_rnw,
    input  bus_pkg::lanes_t     bus_dsn,
    input  bus_pkg::data_t      bus_wdata,
    output logic                ok,
    output bus_pkg::data_t      rdata
);
    localparam int CW = $clog2(WAIT + 1);

    bus_pkg::data_t mem [2**AW];
    logic [CW-1:0]  cnt;
    logic           fire;

    // last wait cycle, ok rises on this edge
    assign fire = sel & ~ok & (cnt == CW'(WAIT - 1));

    initial begin
        for (int i = 0; i < 2**AW; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            ok  <= 1'b0;
        end else if (!sel) begin // restart on the next rising select
            cnt <= '0;
            ok  <= 1'b0;
        end else if (fire) begin
            ok <= 1'b1; // held until the select drops
        end else if (!ok) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (bus_rnw) begin
                rdata <= mem[offset];
            end else begin
                if (!bus_dsn[1]) begin
                    mem[offset][15:8] <= bus_wdata[15:8]; // upper lane
                end
                if (!bus_dsn[0]) begin
                    mem[offset][7:0] <= bus_wdata[7:0]; // lower lane
                end
            end
        end
    end

endmodule

//--- hdl/resp_collector.sv
// response collector that picks the answering bank and registers read data and acknowledge
`timescale 1ns/1ps
`include "sub_bus_cfg.svh"

module resp_collector (
    input  logic                                clk,
    input  logic                                rst,
    input  map_pkg::bank_sel_t                  bank_sel,
    input  map_pkg::bank_sel_t                  bank_ok,
    input  bus_pkg::data_t [`SUB_BANKS-1:0]     bank_rdata,
    input  logic                                unmapped,
    input  logic                                bus_as,
    output logic                                bus_ack,
    output bus_pkg::data_t                      bus_rdata
);
    map_pkg::bank_sel_t hit;
    logic               answer;
    bus_pkg::data_t     hit_data;

    // ok alone may linger one cycle after the select drops
    assign hit    = bank_sel & bank_ok;
    assign answer = (|hit) | unmapped;

    always_comb begin
        hit_data = '1; // unmapped reads float high
        for (int i = 0; i < `SUB_BANKS; i++) begin
            if (hit[i]) begin
                hit_data = bank_rdata[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_ack <= 1'b0;
        end else if (bus_as) begin // strobe released
            bus_ack <= 1'b0;
        end else if (answer) begin
            bus_ack <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!bus_as && answer) begin
            bus_rdata <= hit_data;
        end
    end

endmodule

//--- hdl/sub_bus_top.sv
// sub bus fabric top with arbiter, address decoder, memory banks and response collector
`timescale 1ns/1ps
`include "sub_bus_cfg.svh"

module sub_bus_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                sub_as,
    input  logic                sub_rnw,
    input  bus_pkg::addr_t      sub_addr,
    input  bus_pkg::lanes_t     sub_dsn,
    input  bus_pkg::data_t      sub_dout,
    output bus_pkg::data_t      sub_din,
    output logic                sub_dtackn,
    input  logic                main_br,
    input  logic                main_as,
    input  logic                main_rnw,
    input  bus_pkg::addr_t      main_addr,
    input  bus_pkg::lanes_t     main_dsn,
    input  bus_pkg::data_t      main_dout,
    output logic                main_bg,
    output bus_pkg::data_t      main_din,
    output logic                main_ok
);
    logic                               bus_as;
    logic                               bus_rnw;
    bus_pkg::addr_t                     bus_addr;
    bus_pkg::lanes_t                    bus_dsn;
    bus_pkg::data_t                     bus_wdata;
    logic                               bus_ack;
    bus_pkg::data_t                     bus_rdata;
    map_pkg::bank_sel_t                 bank_sel;
    map_pkg::bank_sel_t                 bank_ok;
    bus_pkg::data_t [`SUB_BANKS-1:0]    bank_rdata;
    logic                               unmapped;
    map_pkg::offset_t                   offset;

    bus_arbiter u_arbiter (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sub_as     ( sub_as     ),
        .sub_rnw    ( sub_rnw    ),
        .sub_addr   ( sub_addr   ),
        .sub_dsn    ( sub_dsn    ),
        .sub_dout   ( sub_dout   ),
        .main_br    ( main_br    ),
        .main_as    ( main_as    ),
        .main_rnw   ( main_rnw   ),
        .main_addr  ( main_addr  ),
        .main_dsn   ( main_dsn   ),
        .main_dout  ( main_dout  ),
        .bus_ack    ( bus_ack    ),
        .bus_rdata  ( bus_rdata  ),
        .sub_dtackn ( sub_dtackn ),
        .sub_din    ( sub_din    ),
        .main_bg    ( main_bg    ),
        .main_ok    ( main_ok    ),
        .main_din   ( main_din   ),
        .bus_as     ( bus_as     ),
        .bus_rnw    ( bus_rnw    ),
        .bus_addr   ( bus_addr   ),
        .bus_dsn    ( bus_dsn    ),
        .bus_wdata  ( bus_wdata  )
    );

    addr_decoder u_decoder (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .bus_as   ( bus_as   ),
        .bus_addr ( bus_addr ),
        .bank_sel ( bank_sel ),
        .unmapped ( unmapped ),
        .offset   ( offset   )
    );

    for (genvar i = 0; i < `SUB_BANKS; i++) begin : g_bank
        mem_bank #(.AW(`BANK_AW), .WAIT(`BANK_WAIT)) u_bank (
            .clk       ( clk           ),
            .rst       ( rst           ),
            .sel       ( bank_sel[i]   ),
            .offset    ( offset        ),
            .bus_rnw   ( bus_rnw       ),
            .bus_dsn   ( bus_dsn       ),
            .bus_wdata ( bus_wdata     ),
            .ok        ( bank_ok[i]    ),
            .rdata     ( bank_rdata[i] )
        );
    end

    resp_collector u_collector (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .bank_sel   ( bank_sel   ),
        .bank_ok    ( bank_ok    ),
        .bank_rdata ( bank_rdata ),
        .unmapped   ( unmapped   ),
        .bus_as     ( bus_as     ),
        .bus_ack    ( bus_ack    ),
        .bus_rdata  ( bus_rdata  )
    );

endmodule

//--- bench/sub_bus_assertions.sv
// protocol assertions on the bus arbiter for acknowledge exclusion, grant state and latency
`timescale 1ns/1ps
`include "sub_bus_cfg.svh"

module sub_bus_assertions (
    input logic                clk,
    input logic                rst,
    input logic                sub_dtackn,
    input logic                main_ok,
    input logic                main_bg,
    input bus_pkg::arb_state_t state,
    input logic                bus_as,
    input logic                bus_ack,
    input bus_pkg::addr_t      bus_addr
);
    int   fail_count = 0; // read by the bench at the end
    logic mapped;

    assign mapped = int'(bus_addr[`REGION_HI:`REGION_LO]) < `SUB_BANKS;

    // each acknowledge only reaches the master that holds the grant
    a_one_ack: assert property (@(posedge clk) disable iff (rst)
        !(main_ok && !main_bg) && !(!sub_dtackn && main_bg))
        else begin
            $error("acknowledge routed to a master that does not hold the bus");
            fail_count++;
        end

    a_no_grant: assert property (@(posedge clk) disable iff (rst)
        state == bus_pkg::SUB_OWN |-> !main_bg)
        else begin
            $error("bus grant active while the sub master owns the bus");
            fail_count++;
        end

    // decode, bank wait states, then the collector register
    a_ack_time: assert property (@(posedge clk) disable iff (rst)
        $fell(bus_as) && mapped |-> ##(`BANK_WAIT + 2) bus_ack)
        else begin
            $error("mapped access not acknowledged in time");
            fail_count++;
        end

endmodule

bind bus_arbiter sub_bus_assertions u_assert (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .sub_dtackn ( sub_dtackn ),
    .main_ok    ( main_ok    ),
    .main_bg    ( main_bg    ),
    .state      ( state      ),
    .bus_as     ( bus_as     ),
    .bus_ack    ( bus_ack    ),
    .bus_addr   ( bus_addr   )
);

//--- bench/sub_bus_monitor.sv
// bus monitor that times each access and compares read data with the expected word
`timescale 1ns/1ps
`include "sub_bus_cfg.svh"

module sub_bus_monitor (
    input logic           clk,
    input logic           rst,
    input logic           sub_as,
    input logic           sub_dtackn,
    input bus_pkg::data_t sub_din,
    input logic           main_as,
    input logic           main_ok,
    input bus_pkg::data_t main_din
);
    string          name;
    logic           on_main;
    logic           is_read;
    bus_pkg::data_t exp_data;
    int             exp_lat;
    int             lat;
    logic           armed = 1'b0;
    int             pass_count = 0;
    int             fail_count = 0;

    // set up the next access before its strobe falls
    task automatic arm(input string t_name, input logic t_main, input logic t_read,
                       input bus_pkg::addr_t t_addr, input bus_pkg::data_t t_exp);
        int region;
        region   = int'(t_addr[`REGION_HI:`REGION_LO]);
        name     = t_name;
        on_main  = t_main;
        is_read  = t_read;
        exp_data = t_exp;
        exp_lat  = (region < `SUB_BANKS) ? `BANK_WAIT + 2 : 2; // unmapped answers after decode
        lat      = 0;
        armed    = 1'b1;
    endtask

    task automatic close_test(input bus_pkg::data_t got);
        logic bad;
        bad = 1'b0;
        if (lat != exp_lat) begin
            $display("** Error %s latency expected %0d actual %0d", name, exp_lat, lat);
            bad = 1'b1;
        end
        if (is_read && got !== exp_data) begin
            $display("** Error %s data expected %h actual %h", name, exp_data, got);
            bad = 1'b1;
        end
        if (bad) begin
            fail_count++;
        end else begin
            pass_count++;
            $display("ok   %s", name);
        end
    endtask

    // negedge sampling, the bench drives on the rising edge
    always @(negedge clk) begin
        if (!rst && armed && (on_main ? !main_as : !sub_as)) begin
            if (on_main ? main_ok : !sub_dtackn) begin
                close_test(on_main ? main_din : sub_din);
                armed = 1'b0;
            end else begin
                lat = lat + 1; // cycles since the strobe edge
            end
        end
    end

endmodule

//--- bench/sub_bus_tb.sv
// testbench for the sub bus fabric, plays both masters from a test file
`timescale 1ns/1ps

module sub_bus_tb;
    logic            clk;
    logic            rst;
    logic            sub_as;
    logic            sub_rnw;
    bus_pkg::addr_t  sub_addr;
    bus_pkg::lanes_t sub_dsn;
    bus_pkg::data_t  sub_dout;
    bus_pkg::data_t  sub_din;
    logic            sub_dtackn;
    logic            main_br;
    logic            main_as;
    logic            main_rnw;
    bus_pkg::addr_t  main_addr;
    bus_pkg::lanes_t main_dsn;
    bus_pkg::data_t  main_dout;
    logic            main_bg;
    bus_pkg::data_t  main_din;
    logic            main_ok;

    // one entry per test line
    string           t_name [$];
    string           t_master [$];
    logic            t_read [$];
    bus_pkg::addr_t  t_addr [$];
    bus_pkg::lanes_t t_dsn [$];
    bus_pkg::data_t  t_wdata [$];
    bus_pkg::data_t  t_exp [$];
    int              grant_errors;
    int              limit_cycles;

    sub_bus_top DUT (.*);

    sub_bus_monitor u_monitor (.*);

    always #50 clk = ~clk;

    task automatic load_tests();
        int          fd;
        int          n;
        string       tok;
        string       rest;
        string       master;
        string       dir;
        logic [19:0] byte_addr;
        logic [1:0]  dsn;
        logic [15:0] wdata;
        logic [15:0] exp_w;
        fd = $fopen("bench/sub_bus_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/sub_bus_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n == 1 && tok.getc(0) == "#") begin
                    n = $fgets(rest, fd); // comment line
                end else if (n == 1) begin
                    n = $fscanf(fd, "%s %s %h %h %h %h", master, dir, byte_addr, dsn, wdata,
                                exp_w);
                    t_name.push_back(tok);
                    t_master.push_back(master);
                    t_read.push_back(dir == "r");
                    t_addr.push_back(byte_addr[19:1]);
                    t_dsn.push_back(dsn);
                    t_wdata.push_back(wdata);
                    t_exp.push_back(exp_w);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic sub_access(input int i, input logic with_request);
        @(posedge clk);
        u_monitor.arm(t_name[i], 1'b0, t_read[i], t_addr[i], t_exp[i]);
        sub_as   <= 1'b0;
        sub_rnw  <= t_read[i];
        sub_addr <= t_addr[i];
        sub_dsn  <= t_dsn[i];
        sub_dout <= t_wdata[i];
        if (with_request) begin
            @(posedge clk);
            main_br <= 1'b1; // request arrives while the sub access runs
        end
        do @(negedge clk); while (sub_dtackn);
        if (with_request && main_bg) begin
            $display("%s: bus granted to main before the sub access was acknowledged", t_name[i]);
            grant_errors++;
        end
        @(posedge clk);
        sub_as <= 1'b1;
        if (with_request) begin
            do @(negedge clk); while (!main_bg);
            @(posedge clk);
            main_br <= 1'b0;
            do @(negedge clk); while (main_bg);
        end
    endtask

    task automatic main_access(input int i);
        @(posedge clk);
        main_br <= 1'b1;
        do @(negedge clk); while (!main_bg);
        @(posedge clk);
        u_monitor.arm(t_name[i], 1'b1, t_read[i], t_addr[i], t_exp[i]);
        main_as   <= 1'b0;
        main_rnw  <= t_read[i];
        main_addr <= t_addr[i];
        main_dsn  <= t_dsn[i];
        main_dout <= t_wdata[i];
        do @(negedge clk); while (!main_ok);
        @(posedge clk);
        main_as <= 1'b1;
        main_br <= 1'b0; // hand the bus back to the sub master
        do @(negedge clk); while (main_bg);
    endtask

    initial begin
        int          idle;
        int          checked;
        int          failed;
        clk          = 1'b0;
        rst          = 1'b1;
        sub_as       = 1'b1;
        sub_rnw      = 1'b1;
        sub_addr     = '0;
        sub_dsn      = 2'b11;
        sub_dout     = '0;
        main_br      = 1'b0;
        main_as      = 1'b1;
        main_rnw     = 1'b1;
        main_addr    = '0;
        main_dsn     = 2'b11;
        main_dout    = '0;
        grant_errors = 0;
        limit_cycles = 0;
        void'($urandom(32'h7b08c68d));
        load_tests();
        limit_cycles = t_name.size() * 20 + 200;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < t_name.size(); i++) begin
            if (t_master[i] == "m") begin
                main_access(i);
            end else begin
                sub_access(i, t_master[i] == "r");
            end
            idle = $urandom % 4;
            repeat (idle) @(posedge clk);
        end
        repeat (2) @(posedge clk);
        checked = u_monitor.pass_count + u_monitor.fail_count;
        failed  = u_monitor.fail_count + grant_errors + DUT.u_arbiter.u_assert.fail_count;
        $display("tests %0d, checked %0d, passed %0d, failed %0d", t_name.size(), checked,
                 u_monitor.pass_count, failed);
        if (failed == 0 && t_name.size() > 0 && checked == t_name.size()) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the number of tests
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, an acknowledge or grant never came", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/bus_pkg.sv
hdl/map_pkg.sv
hdl/bus_arbiter.sv
hdl/addr_decoder.sv
hdl/mem_bank.sv
hdl/resp_collector.sv
hdl/sub_bus_top.sv
bench/sub_bus_assertions.sv
bench/sub_bus_monitor.sv
bench/sub_bus_tb.sv

//--- Makefile
SIM      := verilator
TOP      := sub_bus_tb
FILELIST := compile.f
FLAGS    := --binary --timing --assert -Wno-fatal
RUN_OPTS := +verilator+error+limit+1000
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_OPTS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/sub_bus_tests.txt
# name master dir byte_addr dsn wdata expected, master s=sub m=main r=sub with a main request
# dsn is active low with the upper lane first, expected is checked on reads only
w_b0     s w 00010 0 1234 0000
r_b0     s r 00010 0 0000 1234
w_b1     s w 20022 0 abcd 0000
r_b1     s r 20022 0 0000 abcd
w_b2     s w 400fe 0 5a5a 0000
r_b2     s r 400fe 0 0000 5a5a
w_b3     s w 601fe 0 c3e1 0000
r_b3     s r 601fe 0 0000 c3e1
wu_b0    s w 00010 1 ee99 0000
ru_b0    s r 00010 0 0000 ee34
wl_b1    s w 20022 2 77f0 0000
rl_b1    s r 20022 0 0000 abf0
w_um4    s w 80010 0 dead 0000
r_um4    s r 80010 0 0000 ffff
r_um5    s r a0022 0 0000 ffff
r_um6    s r c0000 0 0000 ffff
w_um7    s w e01fe 0 0bad 0000
r_um7    s r e01fe 0 0000 ffff
chk_b0   s r 00010 0 0000 ee34
chk_b3   s r 601fe 0 0000 c3e1
mw_b2    m w 40100 0 6161 0000
mr_b2    m r 40100 0 0000 6161
mr_b1    m r 20022 0 0000 abf0
sr_b2    s r 40100 0 0000 6161
mwl_b3   m w 60002 2 1142 0000
sr_b3    s r 60002 0 0000 0042
mr_um7   m r e0000 0 0000 ffff
rq_b2    r r 400fe 0 0000 5a5a
rq_b1    r w 20022 0 beef 0000
sr_b1    s r 20022 0 0000 beef
